// ==== hw/cpuPkg.sv ====
package cpuPkg;

	// Widths with a meaning of their own
	typedef logic [15:0] word_t; // Data, address and instruction word
	typedef logic [1:0] regSel_t; // Register file index

	localparam int addrFieldWidth = 11; // Address / immediate field, bits 10..0
	localparam int numRegs = 4;

	// ALU function, taken from instruction bits 2..0
	typedef enum logic [2:0] {
		aluAdd = 3'd0,
		aluSub = 3'd1,
		aluAnd = 3'd2,
		aluOr = 3'd3,
		aluXor = 3'd4,
		aluNotA = 3'd5, // B ignored
		aluShl = 3'd6, // Shift left by one
		aluShr = 3'd7 // Logical shift right by one
	} aluFunc_t;

	// Instruction forms in bits 15..13
	// 010 and 100 fall through as no-ops
	typedef enum logic [2:0] {
		opAlu = 3'b000,
		opLdImm = 3'b001,
		opLdInd = 3'b011,
		opStInd = 3'b101,
		opBrzRel = 3'b110,
		opBrzReg = 3'b111
	} opcode_t;

	// Next PC source
	typedef enum logic [1:0] {
		pcInc = 2'b00, // PC + 1
		pcRel = 2'b01, // PC + sign-extended field
		pcReg = 2'b10 // Register value
	} nextPc_t;

endpackage

// ==== hw/decoder.sv ====
`timescale 1ns/100ps

module decoder (
	input cpuPkg::word_t instruction,

	input logic zFlag, // Flag from before this edge, for BRZ
	output cpuPkg::nextPc_t nextPCSel,

	output logic regDataInSource, // Write back from memory
	output logic immData, // Write back from addr field
	output cpuPkg::regSel_t regInSel,
	output logic regFileWE,
	output cpuPkg::regSel_t regOutSel1,
	output cpuPkg::regSel_t regOutSel2,

	output cpuPkg::aluFunc_t aluFunc,

	output logic memWE,
	output logic dAddrSel, // Register 1 as data address
	output cpuPkg::word_t addr // Extended address field
);

	localparam int extWidth = $bits(cpuPkg::word_t) - cpuPkg::addrFieldWidth;

	cpuPkg::opcode_t opcode;
	logic [cpuPkg::addrFieldWidth-1:0] addrField;

	// Field positions are the same for every form
	// Unused selects are harmless, the enables decide
	assign opcode = cpuPkg::opcode_t'(instruction[15:13]);
	assign regInSel = instruction[12:11];
	assign regOutSel1 = instruction[10:9];
	assign regOutSel2 = instruction[8:7];
	assign addrField = instruction[cpuPkg::addrFieldWidth-1:0];
	assign aluFunc = cpuPkg::aluFunc_t'(instruction[2:0]); // Bits 6..3 reserved

	always_comb begin
		// Everything low unless the opcode says otherwise
		nextPCSel = cpuPkg::pcInc;
		regDataInSource = 1'b0;
		immData = 1'b0;
		regFileWE = 1'b0;
		dAddrSel = 1'b0;
		memWE = 1'b0;
		addr = '0;

		case (opcode)
			cpuPkg::opAlu: begin
				regFileWE = 1'b1; // Result back to regInSel
			end

			cpuPkg::opLdImm: begin
				immData = 1'b1;
				regFileWE = 1'b1;
				addr = {{extWidth{1'b0}}, addrField}; // Zero fill
			end

			cpuPkg::opLdInd: begin
				dAddrSel = 1'b1; // Address from regOut1
				regDataInSource = 1'b1; // Data from memory
				regFileWE = 1'b1;
			end

			cpuPkg::opStInd: begin
				dAddrSel = 1'b1;
				memWE = 1'b1; // regOut2 to memory
			end

			cpuPkg::opBrzRel: begin
				if (zFlag) begin
					nextPCSel = cpuPkg::pcRel;
					// Sign extend for backward jumps
					addr = {{extWidth{addrField[cpuPkg::addrFieldWidth-1]}}, addrField};
				end
			end

			cpuPkg::opBrzReg: begin
				if (zFlag) begin
					nextPCSel = cpuPkg::pcReg; // Target is regOut1
				end
			end

			default: begin
				// 010, 100 do nothing
			end
		endcase
	end

	// No form both writes memory and writes back
	always_comb begin
		assert (!(memWE && regFileWE))
			else $error("decoder: memWE and regFileWE both high, instruction %h", instruction);
	end

endmodule

// ==== hw/regFile.sv ====
`timescale 1ns/100ps

module regFile (
	input logic clk,
	input logic arstN,

	input logic we,
	input cpuPkg::regSel_t wSel,
	input cpuPkg::word_t wData,

	input cpuPkg::regSel_t rSel1,
	input cpuPkg::regSel_t rSel2,
	output cpuPkg::word_t rData1,
	output cpuPkg::word_t rData2
);

	cpuPkg::word_t regs [cpuPkg::numRegs];

	// Single write port, takes effect on the edge
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < cpuPkg::numRegs; i++) begin
				regs[i] <= '0; // All registers start at zero
			end
		end else if (we) begin
			regs[wSel] <= wData;
		end
	end

	// Reads see the value before the edge
	assign rData1 = regs[rSel1];
	assign rData2 = regs[rSel2];

endmodule

// ==== hw/alu.sv ====
`timescale 1ns/100ps

module alu (
	input logic clk,
	input logic arstN,

	input cpuPkg::aluFunc_t func,
	input cpuPkg::word_t a,
	input cpuPkg::word_t b,
	input logic flagWE, // Only ALU instructions touch the flag

	output cpuPkg::word_t result,
	output logic zFlag
);

	always_comb begin
		result = '0;
		case (func)
			cpuPkg::aluAdd: result = a + b;
			cpuPkg::aluSub: result = a - b;
			cpuPkg::aluAnd: result = a & b;
			cpuPkg::aluOr: result = a | b;
			cpuPkg::aluXor: result = a ^ b;
			cpuPkg::aluNotA: result = ~a;
			cpuPkg::aluShl: result = a << 1; // LSB fills with zero
			cpuPkg::aluShr: result = a >> 1; // Logical, MSB zero
			default: result = '0;
		endcase
	end

	// Zero flag holds between ALU instructions
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			zFlag <= 1'b0;
		end else if (flagWE) begin
			zFlag <= (result == '0);
		end
	end

	// Flag reflects the result of the last flag write
	zFlagTracksResult: assert property (
		@(posedge clk) disable iff (!arstN)
		$past(flagWE) |-> (zFlag == ($past(result) == '0))
	) else $error("alu: zFlag does not match previous result");

endmodule

// ==== hw/pcUnit.sv ====
`timescale 1ns/100ps

module pcUnit (
	input logic clk,
	input logic arstN,

	input logic advance, // Low holds the PC
	input cpuPkg::nextPc_t sel,
	input cpuPkg::word_t offset, // Already sign extended
	input cpuPkg::word_t target, // Register branch destination

	output cpuPkg::word_t pc
);

	cpuPkg::word_t nextPc;

	always_comb begin
		case (sel)
			cpuPkg::pcRel: nextPc = pc + offset; // Wraps at 16 bits
			cpuPkg::pcReg: nextPc = target;
			default: nextPc = pc + 16'd1;
		endcase
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc <= '0;
		end else if (advance) begin
			pc <= nextPc;
		end
	end

endmodule

// ==== hw/cpuCore.sv ====
`timescale 1ns/100ps

module cpuCore (
	input logic clk,
	input logic arstN,

	input cpuPkg::word_t instruction,
	output cpuPkg::word_t instrAddr, // Current PC

	output cpuPkg::word_t dAddr,
	output cpuPkg::word_t dataOut,
	input cpuPkg::word_t dataIn, // Combinational read of dAddr
	output logic memWE
);

	logic runFlag;

	cpuPkg::nextPc_t nextPCSel;
	logic regDataInSource;
	logic immData;
	cpuPkg::regSel_t regInSel;
	logic decRegFileWE;
	cpuPkg::regSel_t regOutSel1;
	cpuPkg::regSel_t regOutSel2;
	cpuPkg::aluFunc_t aluFunc;
	logic decMemWE;
	logic dAddrSel;
	cpuPkg::word_t addr;

	cpuPkg::word_t regOut1;
	cpuPkg::word_t regOut2;
	cpuPkg::word_t aluResult;
	cpuPkg::word_t wbData;
	logic zFlag;
	logic regWE;
	logic aluFlagWE;
	logic isAluOp;

	// First edge after reset only sets this and executes nothing
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			runFlag <= 1'b0;
		end else begin
			runFlag <= 1'b1;
		end
	end

	assign isAluOp = (instruction[15:13] == cpuPkg::opAlu);

	// State changes only once running
	assign regWE = decRegFileWE & runFlag;
	assign memWE = decMemWE & runFlag;
	assign aluFlagWE = regWE & isAluOp;

	// Immediate wins over memory on write back
	assign wbData = immData ? addr :
		regDataInSource ? dataIn : aluResult;

	assign dAddr = dAddrSel ? regOut1 : addr; // Indirect or field
	assign dataOut = regOut2; // Store data

	decoder uDecoder (
		.instruction(instruction),
		.zFlag(zFlag),
		.nextPCSel(nextPCSel),
		.regDataInSource(regDataInSource),
		.immData(immData),
		.regInSel(regInSel),
		.regFileWE(decRegFileWE),
		.regOutSel1(regOutSel1),
		.regOutSel2(regOutSel2),
		.aluFunc(aluFunc),
		.memWE(decMemWE),
		.dAddrSel(dAddrSel),
		.addr(addr)
	);

	regFile uRegFile (
		.clk(clk),
		.arstN(arstN),
		.we(regWE),
		.wSel(regInSel),
		.wData(wbData),
		.rSel1(regOutSel1),
		.rSel2(regOutSel2),
		.rData1(regOut1),
		.rData2(regOut2)
	);

	alu uAlu (
		.clk(clk),
		.arstN(arstN),
		.func(aluFunc),
		.a(regOut1),
		.b(regOut2),
		.flagWE(aluFlagWE),
		.result(aluResult),
		.zFlag(zFlag)
	);

	pcUnit uPcUnit (
		.clk(clk),
		.arstN(arstN),
		.advance(runFlag),
		.sel(nextPCSel),
		.offset(addr),
		.target(regOut1), // Register branch target
		.pc(instrAddr)
	);

	// No memory write before the core runs
	noWriteIdle: assert property (
		@(posedge clk) !runFlag |-> !memWE
	) else $error("cpuCore: memWE high while not running");

endmodule

// ==== verif/cpuCoreTb.sv ====
`timescale 1ns/100ps

module cpuCoreTb;

	localparam int numInstr = 2000;
	localparam int resetCycles = 4;
	localparam int cycleLimit = resetCycles + 1 + numInstr + 95; // Idle edge plus margin
	localparam int extWidth = 16 - cpuPkg::addrFieldWidth;

	logic clk;
	logic arstN;
	cpuPkg::word_t instruction;
	cpuPkg::word_t instrAddr;
	cpuPkg::word_t dAddr;
	cpuPkg::word_t dataOut;
	cpuPkg::word_t dataIn;
	logic memWE;

	cpuPkg::word_t dataMem [65536]; // Full 16-bit data space
	logic [31:0] rngState;
	int cycleCount = 0;

	// Shadow model state
	logic mRun;
	cpuPkg::word_t mPc;
	logic mZ;
	cpuPkg::word_t mRegs [cpuPkg::numRegs];

	// Expected port values for the current instruction
	cpuPkg::word_t expDAddr;
	cpuPkg::word_t expDataOut;
	logic expMemWE;
	logic isStore;
	logic isLoad;

	cpuCore uut (
		.clk(clk),
		.arstN(arstN),
		.instruction(instruction),
		.instrAddr(instrAddr),
		.dAddr(dAddr),
		.dataOut(dataOut),
		.dataIn(dataIn),
		.memWE(memWE)
	);

	assign dataIn = dataMem[dAddr]; // Combinational read
	always @(posedge clk) begin
		if (memWE) begin
			dataMem[dAddr] <= dataOut;
		end
	end

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk; // 100 ns period
	end

	always @(posedge clk) cycleCount <= cycleCount + 1;

	task automatic stopOnError(input string line);
		$display("%s", line);
		$display("Something failed");
		$fatal(1, "simulation stopped");
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Weighted mix of forms with short relative jumps
	function automatic cpuPkg::word_t makeInstruction(input logic [31:0] r);
		logic [3:0] kind;
		logic [12:0] body;
		cpuPkg::word_t instr;
		kind = r[19:16];
		body = r[12:0];
		if (kind < 4'd3) instr = {cpuPkg::opAlu, body};
		else if (kind < 4'd6) instr = {cpuPkg::opLdImm, body};
		else if (kind < 4'd8) instr = {cpuPkg::opLdInd, body};
		else if (kind < 4'd11) instr = {cpuPkg::opStInd, body};
		else if (kind < 4'd13) instr = {cpuPkg::opBrzRel, body[12:11], {6{r[4]}}, r[4:0]};
		else if (kind == 4'd13) instr = {cpuPkg::opBrzReg, body};
		else instr = r[31:16]; // Anything including no-op forms
		return instr;
	endfunction

	// Reference ALU for functions 0 to 7
	function automatic cpuPkg::word_t aluRef(input logic [2:0] f, input cpuPkg::word_t a,
		input cpuPkg::word_t b);
		case (f)
			3'd0: return a + b;
			3'd1: return a - b;
			3'd2: return a & b;
			3'd3: return a | b;
			3'd4: return a ^ b;
			3'd5: return ~a;
			3'd6: return {a[14:0], 1'b0};
			3'd7: return {1'b0, a[15:1]};
			default: return '0;
		endcase
	endfunction

	always @(posedge clk or negedge arstN) begin
		cpuPkg::word_t res;
		cpuPkg::word_t field;
		if (!arstN) begin
			mRun <= 1'b0;
			mPc <= '0;
			mZ <= 1'b0;
			for (int i = 0; i < cpuPkg::numRegs; i++) mRegs[i] <= '0;
		end else begin
			mRun <= 1'b1; // First edge only starts the core
			field = {{extWidth{1'b0}}, instruction[cpuPkg::addrFieldWidth-1:0]};
			res = aluRef(instruction[2:0], mRegs[instruction[10:9]], mRegs[instruction[8:7]]);
			if (mRun) begin
				mPc <= mPc + 16'd1;
				case (instruction[15:13])
					cpuPkg::opAlu: begin
						mRegs[instruction[12:11]] <= res;
						mZ <= (res == 16'd0);
					end
					cpuPkg::opLdImm: mRegs[instruction[12:11]] <= field; // Zero extended
					cpuPkg::opLdInd: mRegs[instruction[12:11]] <= dataMem[mRegs[instruction[10:9]]];
					cpuPkg::opBrzRel: begin
						if (mZ) mPc <= mPc + {{extWidth{field[cpuPkg::addrFieldWidth-1]}},
							field[cpuPkg::addrFieldWidth-1:0]};
					end
					cpuPkg::opBrzReg: begin
						if (mZ) mPc <= mRegs[instruction[10:9]];
					end
					default: begin
					end // Store and no-ops leave registers alone
				endcase
			end
		end
	end

	always_comb begin
		isStore = (instruction[15:13] == cpuPkg::opStInd);
		isLoad = (instruction[15:13] == cpuPkg::opLdInd);
		expDAddr = mRegs[instruction[10:9]]; // Indirect address
		expDataOut = mRegs[instruction[8:7]];
		expMemWE = mRun && isStore;
	end

	resetQuiet: assert property (@(posedge clk) !mRun |-> (instrAddr == '0 && !memWE))
		else stopOnError($sformatf("CHECK FAILED at %0t: not idle, instrAddr %h memWE %b",
			$time, instrAddr, memWE));

	pcTracks: assert property (@(posedge clk) disable iff (!arstN) instrAddr == mPc)
		else stopOnError($sformatf("CHECK FAILED at %0t: instrAddr %h, expected %h",
			$time, instrAddr, mPc));

	writeStrobe: assert property (@(posedge clk) disable iff (!arstN) memWE == expMemWE)
		else stopOnError($sformatf("CHECK FAILED at %0t: memWE %b, expected %b",
			$time, memWE, expMemWE));

	storePorts: assert property (@(posedge clk) disable iff (!arstN)
		(mRun && isStore) |-> (dAddr == expDAddr && dataOut == expDataOut))
		else stopOnError($sformatf("CHECK FAILED at %0t: store %h <- %h, expected %h <- %h",
			$time, dAddr, dataOut, expDAddr, expDataOut));

	loadAddress: assert property (@(posedge clk) disable iff (!arstN)
		(mRun && isLoad) |-> dAddr == expDAddr)
		else stopOnError($sformatf("CHECK FAILED at %0t: load address %h, expected %h",
			$time, dAddr, expDAddr));

	initial begin : watchdog
		wait (cycleCount >= cycleLimit);
		stopOnError($sformatf("Timeout: run still going after %0d cycles", cycleLimit));
	end

	initial begin
		cpuPkg::word_t a;
		instruction = '0;
		arstN = 1'b1;
		rngState = 32'h127b;
		for (int i = 0; i < 65536; i++) begin
			a = cpuPkg::word_t'(i);
			dataMem[i] <= {a[3:0], a[15:4]} ^ 16'hc3a5; // Rotated address pattern
		end
		#1 arstN = 1'b0;
		repeat (resetCycles) @(posedge clk);
		#10 arstN = 1'b1;
		@(posedge clk); // Idle edge sets the run flag
		#10;
		for (int k = 0; k < numInstr; k++) begin
			rngState = xorshift(rngState);
			instruction = makeInstruction(rngState);
			@(posedge clk);
			#10;
		end
		$display("Everything OK");
		$finish;
	end

endmodule

// ==== cpuCore.f ====
hw/cpuPkg.sv
hw/decoder.sv
hw/regFile.sv
hw/alu.sv
hw/pcUnit.sv
hw/cpuCore.sv
verif/cpuCoreTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the cpuCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert --timescale 1ns/100ps --top-module cpuCoreTb \
	-f cpuCore.f --Mdir obj_dir -o cpuCoreSim; then
	echo "Verilator build failed"
	exit 1
fi

simOut=$(./obj_dir/cpuCoreSim 2>&1)
simStatus=$?
printf '%s\n' "$simOut"

if [ "$simStatus" -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if printf '%s\n' "$simOut" | grep -q "^Everything OK$"; then
	exit 0
fi

echo "Pass message not found in simulation output"
exit 1
